//--- logic/fix_pkg.sv
`default_nettype none

package fix_pkg;

	// byte widths of the tag and value words
	localparam int VAL_BYTES = 8;
	localparam int TAG_BYTES = 4;

	// first character in the top byte, unused low bytes zero
	typedef logic [8*VAL_BYTES-1:0] field_val_t;
	typedef logic [8*TAG_BYTES-1:0] fix_tag_t;
	typedef logic [3:0] val_size_t;
	typedef logic [2:0] tag_size_t;

	typedef enum logic [1:0] {
		MSG_LOGON,
		MSG_HEARTBEAT,
		MSG_LOGOUT
	} msg_type_t;

	// field order on the wire
	typedef enum logic [3:0] {
		FLD_BEGIN_STRING,
		FLD_BODY_LENGTH,
		FLD_SEQ_NUM,
		FLD_MSG_TYPE,
		FLD_SENDER,
		FLD_SEND_TIME,
		FLD_TARGET,
		FLD_ENCRYPT,
		FLD_HB_INT,
		FLD_CHECKSUM
	} field_id_t;

	localparam field_val_t BEGIN_STRING_VAL = {"FIX.4.2", 8'h00};
	localparam val_size_t BEGIN_STRING_SIZE = 4'd7;

	// MsgType codes
	localparam logic [7:0] MSGTYPE_LOGON = "A";
	localparam logic [7:0] MSGTYPE_HEARTBEAT = "0";
	localparam logic [7:0] MSGTYPE_LOGOUT = "5";

	localparam logic [7:0] ENCRYPT_NONE = "0";
	localparam logic [7:0] ASCII_EQ = 8'h3D;
	localparam logic [7:0] ASCII_SOH = 8'h01;
	localparam logic [7:0] ASCII_ZERO = 8'h30;

	// tag numbers as left aligned strings
	localparam fix_tag_t TAG_BEGIN_STRING = {"8", 24'h0};
	localparam fix_tag_t TAG_BODY_LENGTH = {"9", 24'h0};
	localparam fix_tag_t TAG_SEQ_NUM = {"34", 16'h0};
	localparam fix_tag_t TAG_MSG_TYPE = {"35", 16'h0};
	localparam fix_tag_t TAG_SENDER = {"49", 16'h0};
	localparam fix_tag_t TAG_SEND_TIME = {"52", 16'h0};
	localparam fix_tag_t TAG_TARGET = {"56", 16'h0};
	localparam fix_tag_t TAG_ENCRYPT = {"98", 16'h0};
	localparam fix_tag_t TAG_HB_INT = {"108", 8'h0};
	localparam fix_tag_t TAG_CHECKSUM = {"10", 16'h0};

endpackage

`default_nettype wire

//--- logic/fix_field_sequencer.sv
`default_nettype none

module fix_field_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                start_i,
	input  fix_pkg::msg_type_t  msg_type_i,
	input  logic                field_ready_i,
	output logic                field_valid_o,
	output fix_pkg::field_id_t  field_id_o,
	output fix_pkg::msg_type_t  msg_type_o,
	output logic                load_o,
	output logic                done_o
);
	import fix_pkg::*;

	typedef enum logic {
		S_IDLE,
		S_EMIT
	} state_t;

	state_t    state;
	field_id_t next_field;
	logic      accept;

	assign accept = field_valid_o && field_ready_i;
	assign field_valid_o = (state == S_EMIT);

	// values are captured by the store in the start cycle
	assign load_o = (state == S_IDLE) && start_i;

	always_comb begin
		case (field_id_o)
			FLD_BEGIN_STRING: next_field = FLD_BODY_LENGTH;
			FLD_BODY_LENGTH:  next_field = FLD_SEQ_NUM;
			FLD_SEQ_NUM:      next_field = FLD_MSG_TYPE;
			FLD_MSG_TYPE:     next_field = FLD_SENDER;
			FLD_SENDER:       next_field = FLD_SEND_TIME;
			FLD_SEND_TIME:    next_field = FLD_TARGET;
			// encrypt method and heartbeat interval exist only in logon
			FLD_TARGET: begin
				if (msg_type_o == MSG_LOGON) begin
					next_field = FLD_ENCRYPT;
				end else begin
					next_field = FLD_CHECKSUM;
				end
			end
			FLD_ENCRYPT:      next_field = FLD_HB_INT;
			FLD_HB_INT:       next_field = FLD_CHECKSUM;
			default:          next_field = FLD_CHECKSUM;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			field_id_o <= FLD_BEGIN_STRING;
			msg_type_o <= MSG_HEARTBEAT;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_i) begin
						state <= S_EMIT;
						field_id_o <= FLD_BEGIN_STRING;
						msg_type_o <= msg_type_i;
					end
				end
				S_EMIT: begin
					if (accept) begin
						if (field_id_o == FLD_CHECKSUM) begin
							// checksum is the last field
							state <= S_IDLE;
							done_o <= 1'b1;
						end else begin
							field_id_o <= next_field;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// a stalled field stays on the bus unchanged
	assert property (@(posedge clk) disable iff (rst)
		field_valid_o && !field_ready_i |=> field_valid_o && $stable(field_id_o));

	// end of message is flagged only once the stream has gone quiet
	assert property (@(posedge clk) disable iff (rst)
		!(done_o && field_valid_o));

endmodule

`default_nettype wire

//--- logic/fix_field_store.sv
`default_nettype none

module fix_field_store (
	input  logic                clk,
	input  logic                rst,
	input  logic                load_i,
	input  fix_pkg::msg_type_t  msg_type_i,
	input  fix_pkg::field_id_t  field_id_i,
	input  fix_pkg::field_val_t body_length_i,
	input  fix_pkg::val_size_t  body_length_size_i,
	input  fix_pkg::field_val_t seq_num_i,
	input  fix_pkg::val_size_t  seq_num_size_i,
	input  fix_pkg::field_val_t sender_i,
	input  fix_pkg::val_size_t  sender_size_i,
	input  fix_pkg::field_val_t send_time_i,
	input  fix_pkg::val_size_t  send_time_size_i,
	input  fix_pkg::field_val_t target_i,
	input  fix_pkg::val_size_t  target_size_i,
	input  fix_pkg::field_val_t hb_int_i,
	input  fix_pkg::val_size_t  hb_int_size_i,
	output fix_pkg::fix_tag_t   tag_o,
	output fix_pkg::tag_size_t  tag_size_o,
	output fix_pkg::field_val_t val_o,
	output fix_pkg::val_size_t  val_size_o
);
	import fix_pkg::*;

	field_val_t body_length_r, seq_num_r, sender_r, send_time_r, target_r, hb_int_r;
	val_size_t  body_length_sz, seq_num_sz, sender_sz, send_time_sz, target_sz, hb_int_sz;
	logic [7:0] type_code;

	// value words
	always_ff @(posedge clk) begin
		if (load_i) begin
			body_length_r <= body_length_i;
			seq_num_r <= seq_num_i;
			sender_r <= sender_i;
			send_time_r <= send_time_i;
			target_r <= target_i;
			hb_int_r <= hb_int_i;
		end
	end

	// sizes start out empty
	always_ff @(posedge clk) begin
		if (rst) begin
			body_length_sz <= '0;
			seq_num_sz <= '0;
			sender_sz <= '0;
			send_time_sz <= '0;
			target_sz <= '0;
			hb_int_sz <= '0;
		end else if (load_i) begin
			body_length_sz <= body_length_size_i;
			seq_num_sz <= seq_num_size_i;
			sender_sz <= sender_size_i;
			send_time_sz <= send_time_size_i;
			target_sz <= target_size_i;
			hb_int_sz <= hb_int_size_i;
		end
	end

	always_comb begin
		case (msg_type_i)
			MSG_LOGON:  type_code = MSGTYPE_LOGON;
			MSG_LOGOUT: type_code = MSGTYPE_LOGOUT;
			default:    type_code = MSGTYPE_HEARTBEAT;
		endcase
	end

	always_comb begin
		tag_o = '0;
		tag_size_o = '0;
		val_o = '0;
		val_size_o = '0;
		case (field_id_i)
			FLD_BEGIN_STRING: begin
				tag_o = TAG_BEGIN_STRING;
				tag_size_o = 3'd1;
				val_o = BEGIN_STRING_VAL;
				val_size_o = BEGIN_STRING_SIZE;
			end
			FLD_BODY_LENGTH: begin
				tag_o = TAG_BODY_LENGTH;
				tag_size_o = 3'd1;
				val_o = body_length_r;
				val_size_o = body_length_sz;
			end
			FLD_SEQ_NUM: begin
				tag_o = TAG_SEQ_NUM;
				tag_size_o = 3'd2;
				val_o = seq_num_r;
				val_size_o = seq_num_sz;
			end
			FLD_MSG_TYPE: begin
				tag_o = TAG_MSG_TYPE;
				tag_size_o = 3'd2;
				val_o = {type_code, {(8*(VAL_BYTES-1)){1'b0}}};
				val_size_o = 4'd1;
			end
			FLD_SENDER: begin
				tag_o = TAG_SENDER;
				tag_size_o = 3'd2;
				val_o = sender_r;
				val_size_o = sender_sz;
			end
			FLD_SEND_TIME: begin
				tag_o = TAG_SEND_TIME;
				tag_size_o = 3'd2;
				val_o = send_time_r;
				val_size_o = send_time_sz;
			end
			FLD_TARGET: begin
				tag_o = TAG_TARGET;
				tag_size_o = 3'd2;
				val_o = target_r;
				val_size_o = target_sz;
			end
			FLD_ENCRYPT: begin
				tag_o = TAG_ENCRYPT;
				tag_size_o = 3'd2;
				val_o = {ENCRYPT_NONE, {(8*(VAL_BYTES-1)){1'b0}}};
				val_size_o = 4'd1;
			end
			FLD_HB_INT: begin
				tag_o = TAG_HB_INT;
				tag_size_o = 3'd3;
				val_o = hb_int_r;
				val_size_o = hb_int_sz;
			end
			// digits filled in by the checksum stage
			FLD_CHECKSUM: begin
				tag_o = TAG_CHECKSUM;
				tag_size_o = 3'd2;
				val_size_o = 4'd3;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/fix_checksum.sv
`default_nettype none

module fix_checksum (
	input  logic                clk,
	input  logic                rst,
	input  logic                load_i,
	input  logic                accept_i,
	input  fix_pkg::field_id_t  field_id_i,
	input  fix_pkg::fix_tag_t   tag_i,
	input  fix_pkg::tag_size_t  tag_size_i,
	input  fix_pkg::field_val_t val_i,
	input  fix_pkg::val_size_t  val_size_i,
	output fix_pkg::fix_tag_t   tag_o,
	output fix_pkg::tag_size_t  tag_size_o,
	output fix_pkg::field_val_t val_o,
	output fix_pkg::val_size_t  val_size_o
);
	import fix_pkg::*;

	logic [7:0] sum_r;
	logic [7:0] field_sum;
	logic [7:0] hundreds;
	logic [7:0] tens;
	logic [7:0] ones;
	logic       is_checksum;
	field_val_t checksum_val;

	assign is_checksum = (field_id_i == FLD_CHECKSUM);

	// bytes of one field as "tag=value<SOH>"
	always_comb begin
		field_sum = ASCII_EQ + ASCII_SOH;
		for (int i = 0; i < TAG_BYTES; i++) begin
			if (i < tag_size_i) begin
				field_sum = field_sum + tag_i[8*(TAG_BYTES-1-i) +: 8];
			end
		end
		for (int i = 0; i < VAL_BYTES; i++) begin
			if (i < val_size_i) begin
				field_sum = field_sum + val_i[8*(VAL_BYTES-1-i) +: 8];
			end
		end
	end

	// running sum mod 256, restarts with every message
	always_ff @(posedge clk) begin
		if (rst || load_i) begin
			sum_r <= '0;
		end else if (accept_i && !is_checksum) begin
			sum_r <= sum_r + field_sum;
		end
	end

	// three decimal digits, leading zeros kept
	assign hundreds = ASCII_ZERO + sum_r / 8'd100;
	assign tens = ASCII_ZERO + (sum_r / 8'd10) % 8'd10;
	assign ones = ASCII_ZERO + sum_r % 8'd10;
	assign checksum_val = {hundreds, tens, ones, {(8*(VAL_BYTES-3)){1'b0}}};

	assign tag_o = tag_i;
	assign tag_size_o = tag_size_i;
	assign val_o = is_checksum ? checksum_val : val_i;
	assign val_size_o = val_size_i;

	// an oversized value would drop bytes from the sum
	assert property (@(posedge clk) disable iff (rst)
		accept_i |-> val_size_i <= VAL_BYTES);

endmodule

`default_nettype wire

//--- logic/fix_message_builder.sv
`default_nettype none

module fix_message_builder (
	input  logic                clk,
	input  logic                rst,
	input  logic                start_i,
	input  fix_pkg::msg_type_t  msg_type_i,
	input  fix_pkg::field_val_t body_length_i,
	input  fix_pkg::val_size_t  body_length_size_i,
	input  fix_pkg::field_val_t seq_num_i,
	input  fix_pkg::val_size_t  seq_num_size_i,
	input  fix_pkg::field_val_t sender_i,
	input  fix_pkg::val_size_t  sender_size_i,
	input  fix_pkg::field_val_t send_time_i,
	input  fix_pkg::val_size_t  send_time_size_i,
	input  fix_pkg::field_val_t target_i,
	input  fix_pkg::val_size_t  target_size_i,
	input  fix_pkg::field_val_t hb_int_i,
	input  fix_pkg::val_size_t  hb_int_size_i,
	input  logic                field_ready_i,
	output logic                field_valid_o,
	output fix_pkg::fix_tag_t   tag_o,
	output fix_pkg::tag_size_t  tag_size_o,
	output fix_pkg::field_val_t val_o,
	output fix_pkg::val_size_t  val_size_o,
	output logic                done_o
);
	import fix_pkg::*;

	field_id_t  field_id;
	msg_type_t  msg_type;
	logic       load;
	logic       accept;
	fix_tag_t   store_tag;
	tag_size_t  store_tag_size;
	field_val_t store_val;
	val_size_t  store_val_size;

	assign accept = field_valid_o && field_ready_i;

	fix_field_sequencer i_sequencer (
		.clk           (clk),
		.rst           (rst),
		.start_i       (start_i),
		.msg_type_i    (msg_type_i),
		.field_ready_i (field_ready_i),
		.field_valid_o (field_valid_o),
		.field_id_o    (field_id),
		.msg_type_o    (msg_type),
		.load_o        (load),
		.done_o        (done_o)
	);

	fix_field_store i_store (
		.clk                (clk),
		.rst                (rst),
		.load_i             (load),
		.msg_type_i         (msg_type),
		.field_id_i         (field_id),
		.body_length_i      (body_length_i),
		.body_length_size_i (body_length_size_i),
		.seq_num_i          (seq_num_i),
		.seq_num_size_i     (seq_num_size_i),
		.sender_i           (sender_i),
		.sender_size_i      (sender_size_i),
		.send_time_i        (send_time_i),
		.send_time_size_i   (send_time_size_i),
		.target_i           (target_i),
		.target_size_i      (target_size_i),
		.hb_int_i           (hb_int_i),
		.hb_int_size_i      (hb_int_size_i),
		.tag_o              (store_tag),
		.tag_size_o         (store_tag_size),
		.val_o              (store_val),
		.val_size_o         (store_val_size)
	);

	fix_checksum i_checksum (
		.clk        (clk),
		.rst        (rst),
		.load_i     (load),
		.accept_i   (accept),
		.field_id_i (field_id),
		.tag_i      (store_tag),
		.tag_size_i (store_tag_size),
		.val_i      (store_val),
		.val_size_i (store_val_size),
		.tag_o      (tag_o),
		.tag_size_o (tag_size_o),
		.val_o      (val_o),
		.val_size_o (val_size_o)
	);

endmodule

`default_nettype wire

//--- test/tb_fix_message_builder.sv
`default_nettype none

module tb_fix_message_builder;
	import fix_pkg::*;

	localparam int NUM_TESTS = 5;

	logic       clk;
	logic       rst;
	logic       start_i;
	msg_type_t  msg_type_i;
	field_val_t body_length_i, seq_num_i, sender_i, send_time_i, target_i, hb_int_i;
	val_size_t  body_length_size_i, seq_num_size_i, sender_size_i;
	val_size_t  send_time_size_i, target_size_i, hb_int_size_i;
	logic       field_ready_i;
	logic       field_valid_o;
	fix_tag_t   tag_o;
	tag_size_t  tag_size_o;
	field_val_t val_o;
	val_size_t  val_size_o;
	logic       done_o;

	// values of the next message set before it starts
	field_val_t m_body, m_seq, m_sender, m_time, m_target, m_hb;
	val_size_t  m_body_sz, m_seq_sz, m_sender_sz, m_time_sz, m_target_sz, m_hb_sz;

	// expected field list of the current message
	fix_tag_t   exp_tag[$];
	tag_size_t  exp_tsz[$];
	field_val_t exp_val[$];
	val_size_t  exp_vsz[$];

	logic [31:0] rng_state;
	int          value_errors;
	int          other_errors;

	fix_message_builder i_dut (
		.clk                (clk),
		.rst                (rst),
		.start_i            (start_i),
		.msg_type_i         (msg_type_i),
		.body_length_i      (body_length_i),
		.body_length_size_i (body_length_size_i),
		.seq_num_i          (seq_num_i),
		.seq_num_size_i     (seq_num_size_i),
		.sender_i           (sender_i),
		.sender_size_i      (sender_size_i),
		.send_time_i        (send_time_i),
		.send_time_size_i   (send_time_size_i),
		.target_i           (target_i),
		.target_size_i      (target_size_i),
		.hb_int_i           (hb_int_i),
		.hb_int_size_i      (hb_int_size_i),
		.field_ready_i      (field_ready_i),
		.field_valid_o      (field_valid_o),
		.tag_o              (tag_o),
		.tag_size_o         (tag_size_o),
		.val_o              (val_o),
		.val_size_o         (val_size_o),
		.done_o             (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// string literals arrive right aligned and the wire format wants them left aligned
	function automatic field_val_t left_val(input logic [63:0] raw, input int n);
		return raw << (8 * (VAL_BYTES - n));
	endfunction

	function automatic fix_tag_t left_tag(input logic [31:0] raw, input int n);
		return raw << (8 * (TAG_BYTES - n));
	endfunction

	task automatic put_value(output field_val_t v, output val_size_t s,
		input logic [63:0] raw, input int n);
		v = left_val(raw, n);
		s = val_size_t'(n);
	endtask

	task automatic choose_values(input int variant);
		case (variant)
			0: begin
				put_value(m_body, m_body_sz, "65", 2);
				put_value(m_seq, m_seq_sz, "1", 1);
				put_value(m_sender, m_sender_sz, "CLIENT1", 7);
				put_value(m_time, m_time_sz, "12:30:05", 8);
				put_value(m_target, m_target_sz, "EXCHG", 5);
				put_value(m_hb, m_hb_sz, "30", 2);
			end
			1: begin
				put_value(m_body, m_body_sz, "72", 2);
				put_value(m_seq, m_seq_sz, "27", 2);
				put_value(m_sender, m_sender_sz, "DESK9", 5);
				put_value(m_time, m_time_sz, "08:15:42", 8);
				put_value(m_target, m_target_sz, "VENUE02", 7);
				put_value(m_hb, m_hb_sz, "120", 3);
			end
			default: begin
				put_value(m_body, m_body_sz, "4", 1);
				put_value(m_seq, m_seq_sz, "1234", 4);
				put_value(m_sender, m_sender_sz, "A", 1);
				put_value(m_time, m_time_sz, "23:59:59", 8);
				put_value(m_target, m_target_sz, "BROKERXY", 8);
				put_value(m_hb, m_hb_sz, "5", 1);
			end
		endcase
	endtask

	task automatic add_field(input logic [31:0] tag_raw, input int tsz,
		input field_val_t v, input val_size_t vsz);
		exp_tag.push_back(left_tag(tag_raw, tsz));
		exp_tsz.push_back(tag_size_t'(tsz));
		exp_val.push_back(v);
		exp_vsz.push_back(vsz);
	endtask

	// reference model of one message with the checksum over "tag=value<SOH>" of each field
	task automatic build_expected(input msg_type_t mt);
		logic [7:0] sum;
		logic [7:0] code;
		logic [7:0] rest;
		logic [7:0] hun;
		logic [7:0] ten;
		logic [23:0] digits;
		fix_tag_t t;
		field_val_t v;
		exp_tag.delete();
		exp_tsz.delete();
		exp_val.delete();
		exp_vsz.delete();
		code = (mt == MSG_LOGON) ? "A" : (mt == MSG_LOGOUT) ? "5" : "0";
		add_field("8", 1, left_val("FIX.4.2", 7), 4'd7);
		add_field("9", 1, m_body, m_body_sz);
		add_field("34", 2, m_seq, m_seq_sz);
		add_field("35", 2, left_val(code, 1), 4'd1);
		add_field("49", 2, m_sender, m_sender_sz);
		add_field("52", 2, m_time, m_time_sz);
		add_field("56", 2, m_target, m_target_sz);
		if (mt == MSG_LOGON) begin
			add_field("98", 2, left_val("0", 1), 4'd1);
			add_field("108", 3, m_hb, m_hb_sz);
		end
		sum = 8'h00;
		for (int i = 0; i < exp_tag.size(); i++) begin
			t = exp_tag[i];
			v = exp_val[i];
			for (int b = 0; b < exp_tsz[i]; b++)
				sum = sum + t[8*(TAG_BYTES-1-b) +: 8];
			sum = sum + 8'h3D;
			for (int b = 0; b < exp_vsz[i]; b++)
				sum = sum + v[8*(VAL_BYTES-1-b) +: 8];
			sum = sum + 8'h01;
		end
		// decimal digits by counting down
		rest = sum;
		hun = 8'd0;
		ten = 8'd0;
		while (rest >= 8'd100) begin
			rest = rest - 8'd100;
			hun = hun + 8'd1;
		end
		while (rest >= 8'd10) begin
			rest = rest - 8'd10;
			ten = ten + 8'd1;
		end
		digits = {8'h30 + hun, 8'h30 + ten, 8'h30 + rest};
		add_field("10", 2, left_val(digits, 3), 4'd3);
	endtask

	task automatic check_field(input int idx, input fix_tag_t tag, input tag_size_t tsz,
		input field_val_t val, input val_size_t vsz);
		if (tag_o !== tag) begin
			value_errors++;
			$display("[FAIL] field %0d tag_o expected %h got %h", idx, tag, tag_o);
		end
		if (tag_size_o !== tsz) begin
			value_errors++;
			$display("[FAIL] field %0d tag_size_o expected %h got %h", idx, tsz, tag_size_o);
		end
		if (val_o !== val) begin
			value_errors++;
			$display("[FAIL] field %0d val_o expected %h got %h", idx, val, val_o);
		end
		if (val_size_o !== vsz) begin
			value_errors++;
			$display("[FAIL] field %0d val_size_o expected %h got %h", idx, vsz, val_size_o);
		end
	endtask

	task automatic check_done(input logic expected);
		if (done_o !== expected) begin
			value_errors++;
			$display("[FAIL] done_o expected %h got %h", expected, done_o);
		end
	endtask

	// one message from start to done with outputs sampled on the falling edge
	task automatic run_message(input msg_type_t mt, input logic random_ready,
		input logic stray_start);
		int idx;
		int cycle;
		logic rdy;
		build_expected(mt);
		@(posedge clk);
		start_i <= 1'b1;
		msg_type_i <= mt;
		body_length_i <= m_body;
		body_length_size_i <= m_body_sz;
		seq_num_i <= m_seq;
		seq_num_size_i <= m_seq_sz;
		sender_i <= m_sender;
		sender_size_i <= m_sender_sz;
		send_time_i <= m_time;
		send_time_size_i <= m_time_sz;
		target_i <= m_target;
		target_size_i <= m_target_sz;
		hb_int_i <= m_hb;
		hb_int_size_i <= m_hb_sz;
		idx = 0;
		cycle = 0;
		while (idx < exp_tag.size()) begin
			@(posedge clk);
			rdy = 1'b1;
			if (random_ready) begin
				rng_state = xorshift32(rng_state);
				rdy = (rng_state[1:0] != 2'b00);
			end
			field_ready_i <= rdy;
			// a start while busy is ignored and so is the type
			start_i <= stray_start && (cycle == 3);
			msg_type_i <= (mt == MSG_LOGON) ? MSG_LOGOUT : MSG_LOGON;
			@(negedge clk);
			// from start up to the checksum accept a field is always on offer
			if (field_valid_o !== 1'b1) begin
				other_errors++;
				$display("field valid was low in a cycle of an unfinished message");
			end
			check_done(1'b0);
			if (field_valid_o === 1'b1) begin
				check_field(idx, exp_tag[idx], exp_tsz[idx], exp_val[idx], exp_vsz[idx]);
				if (field_ready_i)
					idx++;
			end
			cycle++;
		end
		@(posedge clk);
		start_i <= 1'b0;
		@(negedge clk);
		check_done(1'b1);
		if (field_valid_o !== 1'b0) begin
			other_errors++;
			$display("a field was still valid after the checksum field was accepted");
		end
		@(posedge clk);
		@(negedge clk);
		check_done(1'b0);
	endtask

	task automatic test_after_reset();
		repeat (2) begin
			@(negedge clk);
			if (field_valid_o !== 1'b0) begin
				other_errors++;
				$display("field valid is high after reset with no message started");
			end
			check_done(1'b0);
		end
	endtask

	task automatic test_logon_full_ready();
		choose_values(0);
		run_message(MSG_LOGON, 1'b0, 1'b0);
	endtask

	task automatic test_short_messages();
		choose_values(1);
		run_message(MSG_HEARTBEAT, 1'b0, 1'b0);
		run_message(MSG_LOGOUT, 1'b0, 1'b0);
	endtask

	task automatic test_random_ready();
		choose_values(2);
		run_message(MSG_LOGON, 1'b1, 1'b1);
		run_message(MSG_HEARTBEAT, 1'b1, 1'b0);
	endtask

	// sum has to restart for each message
	task automatic test_back_to_back();
		choose_values(1);
		run_message(MSG_LOGON, 1'b0, 1'b0);
		choose_values(2);
		run_message(MSG_LOGON, 1'b0, 1'b0);
	endtask

	initial begin
		#(NUM_TESTS * 40 * 100);
		$display("timeout: the tests did not complete in the expected time");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		rng_state = 32'd17;
		value_errors = 0;
		other_errors = 0;
		rst = 1'b1;
		start_i = 1'b0;
		msg_type_i = MSG_HEARTBEAT;
		body_length_i = '0;
		body_length_size_i = '0;
		seq_num_i = '0;
		seq_num_size_i = '0;
		sender_i = '0;
		sender_size_i = '0;
		send_time_i = '0;
		send_time_size_i = '0;
		target_i = '0;
		target_size_i = '0;
		hb_int_i = '0;
		hb_int_size_i = '0;
		field_ready_i = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_after_reset();
		test_logon_full_ready();
		test_short_messages();
		test_random_ready();
		test_back_to_back();
		$display("value mismatches: %0d, other failures: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
logic/fix_pkg.sv
logic/fix_field_sequencer.sv
logic/fix_field_store.sv
logic/fix_checksum.sv
logic/fix_message_builder.sv
test/tb_fix_message_builder.sv
